// File: common/ext_bus_pkg.sv
// ----------------------------------------------------------------------
// External bus definitions
// Widths, memory map and response timing of the harness OBI bus
// ----------------------------------------------------------------------

package ext_bus_pkg;

  // Bus widths
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned BE_WIDTH       = DATA_WIDTH / 8;
  localparam int unsigned WORD_IDX_WIDTH = 10;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [BE_WIDTH-1:0]       be_t;
  typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;

  // ----------------------------------------------------------------------
  // Memory map
  // ----------------------------------------------------------------------
  localparam addr_t       SLOW_MEM0_BASE = 32'hF000_0000;
  localparam addr_t       SLOW_MEM1_BASE = 32'hF000_1000;
  localparam int unsigned SLOW_MEM_SIZE  = 4096;
  localparam int unsigned SLOW_MEM_WORDS = SLOW_MEM_SIZE / BE_WIDTH;

  // Cycles from grant to rvalid
  localparam int unsigned SLOW_LATENCY = 2;

  // Read data for an address outside both windows
  localparam data_t ERROR_RDATA = 32'hBADC_AB1E;

  // Where a transfer is routed
  typedef enum logic [1:0] {
    TGT_MEM0,
    TGT_MEM1,
    TGT_ERR
  } target_e;

endpackage

// File: common/power_pkg.sv
// ----------------------------------------------------------------------
// Power domain definitions
// Domain count and switch acknowledge timing
// ----------------------------------------------------------------------

package power_pkg;

  // One domain each for cpu, peripheral and external subsystems
  localparam int unsigned POWER_DOMAINS = 3;

  // Delay from switch request to acknowledge
  localparam int unsigned SWITCH_ACK_LATENCY = 16;

  // One bit per domain, active low
  typedef logic [POWER_DOMAINS-1:0] domain_vec_t;

endpackage

// File: common/obi_if.sv
// ----------------------------------------------------------------------
// OBI bus bundle
// Request and response signals of one non-stalling OBI link
// ----------------------------------------------------------------------

interface obi_if;
  import ext_bus_pkg::*;

  // Request channel
  logic  req;
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;

  // Response channel, no back-pressure
  logic  rvalid;
  data_t rdata;

  modport manager (
    output req, we, be, addr, wdata,
    input  rvalid, rdata
  );

  modport subordinate (
    input  req, we, be, addr, wdata,
    output rvalid, rdata
  );

endinterface

// File: ext_bus/slow_memory.sv
// ----------------------------------------------------------------------
// Slow memory
// Byte-enabled word memory with a fixed, fully pipelined response delay
// ----------------------------------------------------------------------

module slow_memory #(
  parameter int unsigned NUM_WORDS = ext_bus_pkg::SLOW_MEM_WORDS
) (
  input  logic       clk_i,
  input  logic       reset_i,
  obi_if.subordinate bus_i
);
  import ext_bus_pkg::*;

  data_t mem_q [NUM_WORDS];

  word_idx_t word_idx;

  // Response pipeline
  logic [SLOW_LATENCY-1:0] valid_q;
  data_t                   rdata_q [SLOW_LATENCY];

  assign word_idx = bus_i.addr[WORD_IDX_WIDTH+1:2];

  // ----------------------------------------------------------------------
  // Storage access at the accepting edge
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus_i.req && bus_i.we) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (bus_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read word captured in the first slot, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (bus_i.req && !bus_i.we) begin
      rdata_q[0] <= mem_q[word_idx];
    end else begin
      rdata_q[0] <= '0;
    end
    for (int i = 1; i < SLOW_LATENCY; i++) begin
      rdata_q[i] <= rdata_q[i-1];
    end
  end

  // One response per accepted transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[SLOW_LATENCY-2:0], bus_i.req};
    end
  end

  assign bus_i.rvalid = valid_q[SLOW_LATENCY-1];
  assign bus_i.rdata  = rdata_q[SLOW_LATENCY-1];

endmodule

// File: ext_bus/ext_obi_demux.sv
// ----------------------------------------------------------------------
// External OBI demux
// Routes each transfer to a slow memory or the error responder and
// returns the responses in order
// ----------------------------------------------------------------------

module ext_obi_demux (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               obi_req_i,
  input  logic               obi_we_i,
  input  ext_bus_pkg::be_t   obi_be_i,
  input  ext_bus_pkg::addr_t obi_addr_i,
  input  ext_bus_pkg::data_t obi_wdata_i,
  output logic               obi_gnt_o,
  output logic               obi_rvalid_o,
  output ext_bus_pkg::data_t obi_rdata_o,
  obi_if.manager             mem0_o,
  obi_if.manager             mem1_o
);
  import ext_bus_pkg::*;

  localparam addr_t WINDOW_MASK = ~addr_t'(SLOW_MEM_SIZE - 1);

  target_e   req_tgt;
  word_idx_t req_idx;
  addr_t     mem_addr;

  // Response tracking, one slot per cycle of latency
  target_e                 tgt_q [SLOW_LATENCY];
  logic                    we_q  [SLOW_LATENCY];
  logic [SLOW_LATENCY-1:0] err_q;

  target_e resp_tgt;
  logic    err_rvalid;
  data_t   err_rdata;

  // ----------------------------------------------------------------------
  // Address decode and request routing
  // ----------------------------------------------------------------------
  always_comb begin
    if ((obi_addr_i & WINDOW_MASK) == SLOW_MEM0_BASE) begin
      req_tgt = TGT_MEM0;
    end else if ((obi_addr_i & WINDOW_MASK) == SLOW_MEM1_BASE) begin
      req_tgt = TGT_MEM1;
    end else begin
      req_tgt = TGT_ERR;
    end
  end

  // Memories never stall
  assign obi_gnt_o = obi_req_i;

  // Offset inside the window, word aligned
  assign req_idx  = obi_addr_i[WORD_IDX_WIDTH+1:2];
  assign mem_addr = addr_t'({req_idx, 2'b00});

  assign mem0_o.req   = obi_req_i && (req_tgt == TGT_MEM0);
  assign mem0_o.we    = obi_we_i;
  assign mem0_o.be    = obi_be_i;
  assign mem0_o.addr  = mem_addr;
  assign mem0_o.wdata = obi_wdata_i;

  assign mem1_o.req   = obi_req_i && (req_tgt == TGT_MEM1);
  assign mem1_o.we    = obi_we_i;
  assign mem1_o.be    = obi_be_i;
  assign mem1_o.addr  = mem_addr;
  assign mem1_o.wdata = obi_wdata_i;

  // ----------------------------------------------------------------------
  // In-flight target pipeline
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= '0;
    end else begin
      err_q <= {err_q[SLOW_LATENCY-2:0], obi_req_i && (req_tgt == TGT_ERR)};
    end
  end

  always_ff @(posedge clk_i) begin
    tgt_q[0] <= req_tgt;
    we_q[0]  <= obi_we_i;
    for (int i = 1; i < SLOW_LATENCY; i++) begin
      tgt_q[i] <= tgt_q[i-1];
      we_q[i]  <= we_q[i-1];
    end
  end

  // Error responder, write data is dropped
  assign resp_tgt   = tgt_q[SLOW_LATENCY-1];
  assign err_rvalid = err_q[SLOW_LATENCY-1];
  assign err_rdata  = we_q[SLOW_LATENCY-1] ? '0 : ERROR_RDATA;

  // Response return from the slot recorded at grant
  always_comb begin
    case (resp_tgt)
      TGT_MEM0: begin
        obi_rvalid_o = mem0_o.rvalid;
        obi_rdata_o  = mem0_o.rdata;
      end
      TGT_MEM1: begin
        obi_rvalid_o = mem1_o.rvalid;
        obi_rdata_o  = mem1_o.rdata;
      end
      default: begin
        obi_rvalid_o = err_rvalid;
        obi_rdata_o  = err_rdata;
      end
    endcase
  end

endmodule

// File: source/power_switch_emulator.sv
// ----------------------------------------------------------------------
// Power switch emulator
// Delays each domain switch request into its acknowledge
// ----------------------------------------------------------------------

module power_switch_emulator (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  power_pkg::domain_vec_t switch_n_i,
  output power_pkg::domain_vec_t switch_ack_n_o
);
  import power_pkg::*;

  // Physical settling of the switches, one stage per cycle
  domain_vec_t ack_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // All domains report switched off
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_q[i] <= '1;
      end
    end else begin
      ack_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_q[i] <= ack_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = ack_q[SWITCH_ACK_LATENCY-1];

endmodule

// File: source/gpio_event_counter.sv
// ----------------------------------------------------------------------
// GPIO event counter
// Counts rising edges and pulses an interrupt every CNT_MAX edges
// ----------------------------------------------------------------------

module gpio_event_counter #(
  parameter int unsigned CNT_MAX = 16
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic gpio_i,
  output logic gpio_intr_o
);

  localparam int unsigned CNT_W = $clog2(CNT_MAX + 1);

  logic             gpio_q;
  logic             gpio_prev_q;
  logic             rise;
  logic [CNT_W-1:0] cnt_q;
  logic             intr_q;

  // Edge seen one cycle after sampling
  assign rise = gpio_q && !gpio_prev_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_q      <= 1'b0;
      gpio_prev_q <= 1'b0;
      cnt_q       <= '0;
      intr_q      <= 1'b0;
    end else begin
      gpio_q      <= gpio_i;
      gpio_prev_q <= gpio_q;
      intr_q      <= 1'b0;
      if (rise) begin
        if (cnt_q == CNT_W'(CNT_MAX - 1)) begin
          cnt_q  <= '0;
          intr_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign gpio_intr_o = intr_q;

endmodule

// File: source/ext_harness_top.sv
// ----------------------------------------------------------------------
// External harness top level
// Slow memory bus, power switch emulation and GPIO event counter
// ----------------------------------------------------------------------

module ext_harness_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // OBI slave port
  input  logic                   obi_req_i,
  input  logic                   obi_we_i,
  input  ext_bus_pkg::be_t       obi_be_i,
  input  ext_bus_pkg::addr_t     obi_addr_i,
  input  ext_bus_pkg::data_t     obi_wdata_i,
  output logic                   obi_gnt_o,
  output logic                   obi_rvalid_o,
  output ext_bus_pkg::data_t     obi_rdata_o,
  // Power switches
  input  power_pkg::domain_vec_t switch_n_i,
  output power_pkg::domain_vec_t switch_ack_n_o,
  // GPIO
  input  logic                   gpio_i,
  output logic                   gpio_intr_o
);

  obi_if mem0_bus ();
  obi_if mem1_bus ();

  // Memory bus
  ext_obi_demux ext_obi_demux_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .obi_req_i   (obi_req_i),
    .obi_we_i    (obi_we_i),
    .obi_be_i    (obi_be_i),
    .obi_addr_i  (obi_addr_i),
    .obi_wdata_i (obi_wdata_i),
    .obi_gnt_o   (obi_gnt_o),
    .obi_rvalid_o(obi_rvalid_o),
    .obi_rdata_o (obi_rdata_o),
    .mem0_o      (mem0_bus),
    .mem1_o      (mem1_bus)
  );

  slow_memory slow_mem0_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bus_i  (mem0_bus)
  );

  slow_memory slow_mem1_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bus_i  (mem1_bus)
  );

  power_switch_emulator power_switch_emulator_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .switch_n_i    (switch_n_i),
    .switch_ack_n_o(switch_ack_n_o)
  );

  gpio_event_counter gpio_event_counter_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .gpio_i     (gpio_i),
    .gpio_intr_o(gpio_intr_o)
  );

endmodule

// File: testbench/ext_harness_properties.sv
// ----------------------------------------------------------------------
// Harness properties
// Grant, response timing and power acknowledge checks on the top level
// ----------------------------------------------------------------------

module ext_harness_properties (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   obi_req_i,
  input logic                   obi_gnt_o,
  input logic                   obi_rvalid_o,
  input power_pkg::domain_vec_t switch_ack_n_o
);
  import ext_bus_pkg::*;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_gnt_o |-> obi_req_i)
    else begin
      fail_count++;
      $error("obi_gnt_o high without obi_req_i");
    end

  // One response per grant after a fixed latency
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rvalid_o == $past(obi_gnt_o, SLOW_LATENCY))
    else begin
      fail_count++;
      $error("obi_rvalid_o does not follow obi_gnt_o by the response latency");
    end

  ack_off_in_reset: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> switch_ack_n_o == '1)
    else begin
      fail_count++;
      $error("switch_ack_n_o not all ones during reset");
    end

endmodule

// File: testbench/tb_ext_harness.sv
// ----------------------------------------------------------------------
// External harness testbench
// Directed tests of the memory bus, power switches and GPIO counter
// ----------------------------------------------------------------------

module tb_ext_harness;
  import ext_bus_pkg::*;
  import power_pkg::*;

  localparam int unsigned GPIO_CNT_MAX = 16;
  localparam int unsigned WAIT_LIMIT   = 64;

  logic        clk_i;
  logic        reset_i;
  logic        obi_req_i;
  logic        obi_we_i;
  be_t         obi_be_i;
  addr_t       obi_addr_i;
  data_t       obi_wdata_i;
  logic        obi_gnt_o;
  logic        obi_rvalid_o;
  data_t       obi_rdata_o;
  domain_vec_t switch_n_i;
  domain_vec_t switch_ack_n_o;
  logic        gpio_i;
  logic        gpio_intr_o;

  integer seed = 32'hec60_7ac4;
  data_t  model_mem [2*SLOW_MEM_WORDS];
  data_t  rsp_q [$];
  int     intr_cycles = 0;

  ext_harness_top UUT (.*);

  bind ext_harness_top ext_harness_properties ext_harness_properties_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Responses and interrupt pulses sampled at the falling edge
  always @(negedge clk_i) begin
    if (obi_rvalid_o) begin
      rsp_q.push_back(obi_rdata_o);
    end
    if (gpio_intr_o) begin
      intr_cycles++;
    end
  end

  // Failures of the bound property checker
  always @(negedge clk_i) begin
    if (UUT.ext_harness_properties_i.fail_count != 0) begin
      report_failure("A concurrent assertion in ext_harness_properties failed");
    end
  end

  // ----------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_domain(string name, domain_vec_t got, domain_vec_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_logic(string name, logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      report_failure($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // Memory model from the address map
  // ----------------------------------------------------------------------
  function automatic int model_slot(addr_t addr);
    if ((addr - SLOW_MEM0_BASE) < SLOW_MEM_SIZE) begin
      return int'((addr - SLOW_MEM0_BASE) >> 2);
    end
    if ((addr - SLOW_MEM1_BASE) < SLOW_MEM_SIZE) begin
      return SLOW_MEM_WORDS + int'((addr - SLOW_MEM1_BASE) >> 2);
    end
    return -1;
  endfunction

  function automatic addr_t word_addr(addr_t base, word_idx_t idx);
    return base + addr_t'({idx, 2'b00});
  endfunction

  function automatic data_t expected_read(addr_t addr);
    int slot;
    slot = model_slot(addr);
    return (slot < 0) ? ERROR_RDATA : model_mem[slot];
  endfunction

  task automatic model_write(addr_t addr, be_t be, data_t wdata);
    int slot;
    slot = model_slot(addr);
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (slot >= 0 && be[b]) begin
        model_mem[slot][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus driving
  // ----------------------------------------------------------------------
  task automatic drive_transfer(logic we, be_t be, addr_t addr, data_t wdata);
    @(posedge clk_i);
    obi_req_i   <= 1'b1;
    obi_we_i    <= we;
    obi_be_i    <= be;
    obi_addr_i  <= addr;
    obi_wdata_i <= wdata;
    @(negedge clk_i);
    check_logic("obi_gnt_o", obi_gnt_o, 1'b1);
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    obi_req_i <= 1'b0;
    obi_we_i  <= 1'b0;
  endtask

  task automatic collect_response(output data_t rdata);
    int cycles;
    cycles = 0;
    while (rsp_q.size() == 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (rsp_q.size() == 0) begin
      report_failure("Timed out waiting for a response on obi_rvalid_o");
    end
    rdata = rsp_q.pop_front();
  endtask

  task automatic write_word(addr_t addr, be_t be, data_t wdata);
    data_t rsp;
    drive_transfer(1'b1, be, addr, wdata);
    drive_idle();
    collect_response(rsp);
    check_data("obi_rdata_o", rsp, '0);
    model_write(addr, be, wdata);
  endtask

  task automatic read_word(addr_t addr);
    data_t rsp;
    drive_transfer(1'b0, '1, addr, '0);
    drive_idle();
    collect_response(rsp);
    check_data("obi_rdata_o", rsp, expected_read(addr));
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_full_words();
    word_idx_t idx;
    repeat (8) begin
      idx = word_idx_t'($random(seed));
      write_word(word_addr(SLOW_MEM0_BASE, idx), '1, $random(seed));
      // Same offset in MEM1 must not overwrite MEM0
      write_word(word_addr(SLOW_MEM1_BASE, idx), '1, $random(seed));
      read_word(word_addr(SLOW_MEM0_BASE, idx));
      read_word(word_addr(SLOW_MEM1_BASE, idx));
    end
  endtask

  task automatic test_partial_writes();
    addr_t addr;
    be_t   patterns [6] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000, 4'b0101};
    addr = word_addr(SLOW_MEM1_BASE, word_idx_t'($random(seed)));
    write_word(addr, '1, $random(seed));
    foreach (patterns[i]) begin
      write_word(addr, patterns[i], $random(seed));
      read_word(addr);
    end
  endtask

  task automatic test_back_to_back();
    addr_t addr [4];
    data_t exp_q [$];
    data_t wdata;
    data_t rsp;
    foreach (addr[i]) begin
      addr[i] = word_addr((i % 2) ? SLOW_MEM1_BASE : SLOW_MEM0_BASE,
                          word_idx_t'($random(seed)));
    end
    foreach (addr[i]) begin
      wdata = $random(seed);
      drive_transfer(1'b1, '1, addr[i], wdata);
      model_write(addr[i], '1, wdata);
      exp_q.push_back('0);
    end
    foreach (addr[i]) begin
      drive_transfer(1'b0, '1, addr[i], '0);
      exp_q.push_back(expected_read(addr[i]));
    end
    drive_idle();
    foreach (exp_q[i]) begin
      collect_response(rsp);
      check_data("obi_rdata_o", rsp, exp_q[i]);
    end
  endtask

  task automatic test_unmapped();
    word_idx_t idx;
    idx = word_idx_t'($random(seed));
    write_word(word_addr(SLOW_MEM0_BASE, idx), '1, $random(seed));
    write_word(word_addr(SLOW_MEM1_BASE, idx), '1, $random(seed));
    read_word(32'hF000_2000);
    read_word(32'h0000_0100);
    write_word(word_addr(32'hF000_2000, idx), '1, $random(seed));
    write_word(word_addr(32'h0000_0000, idx), '1, $random(seed));
    read_word(word_addr(SLOW_MEM0_BASE, idx));
    read_word(word_addr(SLOW_MEM1_BASE, idx));
  endtask

  task automatic toggle_domain(int d);
    domain_vec_t prev;
    domain_vec_t next;
    int          cycles;
    prev = switch_n_i;
    next = prev ^ (domain_vec_t'(1) << d);
    @(posedge clk_i);
    switch_n_i <= next;
    cycles = 0;
    @(negedge clk_i);
    while (switch_ack_n_o !== next && cycles < WAIT_LIMIT) begin
      check_domain("switch_ack_n_o", switch_ack_n_o, prev);
      cycles++;
      @(negedge clk_i);
    end
    if (cycles >= WAIT_LIMIT) begin
      report_failure("Timed out waiting for switch_ack_n_o to follow switch_n_i");
    end
    check_count("switch_ack_n_o latency", cycles, SWITCH_ACK_LATENCY);
  endtask

  task automatic test_power_switches();
    for (int d = 0; d < POWER_DOMAINS; d++) begin
      toggle_domain(d);
      toggle_domain(d);
    end
  endtask

  task automatic gpio_edge();
    @(posedge clk_i);
    gpio_i <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    gpio_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic test_gpio_counter();
    int cycles;
    repeat (GPIO_CNT_MAX - 1) gpio_edge();
    check_count("gpio_intr_o pulses", intr_cycles, 0);
    gpio_edge();
    cycles = 0;
    while (intr_cycles == 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (intr_cycles == 0) begin
      report_failure("Timed out waiting for gpio_intr_o");
    end
    @(negedge clk_i);
    check_logic("gpio_intr_o", gpio_intr_o, 1'b0);
    check_count("gpio_intr_o high cycles", intr_cycles, 1);
    // One edge short of the next interrupt
    repeat (GPIO_CNT_MAX - 1) gpio_edge();
    repeat (4) @(negedge clk_i);
    check_count("gpio_intr_o high cycles", intr_cycles, 1);
  endtask

  initial begin
    reset_i     = 1'b1;
    obi_req_i   = 1'b0;
    obi_we_i    = 1'b0;
    obi_be_i    = '0;
    obi_addr_i  = '0;
    obi_wdata_i = '0;
    switch_n_i  = '1;
    gpio_i      = 1'b0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_logic("obi_rvalid_o", obi_rvalid_o, 1'b0);
    check_domain("switch_ack_n_o", switch_ack_n_o, '1);
    test_full_words();
    test_partial_writes();
    test_back_to_back();
    test_unmapped();
    test_power_switches();
    test_gpio_counter();
    if (UUT.ext_harness_properties_i.fail_count != 0) begin
      report_failure("A concurrent assertion in ext_harness_properties failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: list.f
common/ext_bus_pkg.sv
common/power_pkg.sv
common/obi_if.sv
ext_bus/slow_memory.sv
ext_bus/ext_obi_demux.sv
source/power_switch_emulator.sv
source/gpio_event_counter.sv
source/ext_harness_top.sv
testbench/ext_harness_properties.sv
testbench/tb_ext_harness.sv

// File: Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tb_ext_harness

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_ext_harness -Mdir obj_dir
	./obj_dir/Vtb_ext_harness | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
